// File: hw/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 16;
	localparam int regAddrWidth = $clog2(regCount);
	localparam int shiftWidth = $clog2(dataWidth);
	localparam int offsetWidth = 8;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regIdxT;

	// One instruction takes one cycle in each phase
	typedef enum logic [1:0] {
		phFetch,
		phDecode,
		phExecute,
		phCommit
	} phaseT;

	// Instruction group, bits 15:13
	localparam logic [2:0] grpAluReg = 3'd0;
	localparam logic [2:0] grpAluImm4 = 3'd1;
	localparam logic [2:0] grpAluImm8 = 3'd2;
	localparam logic [2:0] grpLdSt = 3'd3;
	localparam logic [2:0] grpJump = 3'd4;
	localparam logic [2:0] grpSys = 3'd5;

	typedef enum logic [3:0] {
		opMov, opAdd, opSub, opAnd, opOr, opXor,
		opSl, opSr, opSra, opRot, opSet, opClr
	} aluOpT;

	// mode is bit 12: store for LD/ST, jump on Z clear for jumps
	typedef struct packed {
		logic [2:0] grp;
		logic       mode;
		logic [3:0] op;
		regIdxT     rd;
		regIdxT     rs;
	} instrT;

	// Jump flags inside the op field (bits 11 and 10)
	localparam int jmpCondIdx = 3;
	localparam int jmpRelIdx = 2;

	localparam regIdxT regRb = 4'd11;

endpackage

// File: hw/coreIfs.sv
`timescale 1ns/1ps

interface aluIf import cpuPkg::*; ();
	aluOpT op;
	logic  immSel;
	wordT  imm;
	logic  flagEn;
	wordT  a;
	wordT  b;
	wordT  result;
	logic  zero;

	modport ctrl (output op, immSel, imm, flagEn);
	modport alu (input op, immSel, imm, flagEn, a, b, output result, zero);
endinterface

interface regPortIf import cpuPkg::*; ();
	regIdxT rdSel;
	regIdxT rsSel;
	regIdxT wrSel;
	logic   wrEn;
	logic   loadSel;

	modport ctrl (output rdSel, rsSel, wrSel, wrEn, loadSel);
	modport regs (input rdSel, rsSel, wrSel, wrEn, loadSel);
endinterface

// File: hw/phaseControl.sv
`timescale 1ns/1ps

module phaseControl import cpuPkg::*; (
	input  logic                   CLK,
	input  logic                   rstN,
	aluIf.ctrl                     alu,
	regPortIf.ctrl                 regs,
	input  wordT                   instr,
	input  logic                   zero,
	output phaseT                  phase,
	output logic                   memRead,
	output logic                   memWrite,
	output logic                   jumpTaken,
	output logic                   jumpRel,
	output logic [offsetWidth-1:0] offset
);

	phaseT  nextPhase;
	logic   running;
	instrT  instrReg;
	instrT  ir;
	regIdxT destReg;
	logic   isAluGrp;
	logic   isLoad;
	logic   isStore;
	logic   isJump;
	logic   condMet;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= phFetch;
			running <= 1'b0;
		end else begin
			phase <= nextPhase;
			running <= 1'b1;
		end
	end

	// First cycle out of reset stays in FETCH and does the first read
	assign nextPhase = running ? phaseT'(phase + 2'd1) : phFetch;

	// Fetched word sits in the bus capture register during DECODE only
	always_ff @(posedge CLK) begin
		if (phase == phDecode) begin
			instrReg <= instr;
		end
	end

	assign ir = (phase == phDecode) ? instrT'(instr) : instrReg;

	always_comb begin
		isAluGrp = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isJump = 1'b0;
		case (ir.grp)
			grpAluReg, grpAluImm4, grpAluImm8: begin
				isAluGrp = 1'b1;
			end
			grpLdSt: begin
				isLoad = !ir.mode;
				isStore = ir.mode;
			end
			grpJump: begin
				isJump = 1'b1;
			end
			// NOP only steps the PC
			grpSys: begin
			end
			default: begin
			end
		endcase
	end

	// 8-bit immediate always targets RB
	assign destReg = (ir.grp == grpAluImm8) ? regRb : ir.rd;

	assign regs.rdSel = destReg;
	assign regs.rsSel = ir.rs;
	assign regs.wrSel = destReg;
	assign regs.wrEn = (phase == phCommit) && (isAluGrp || isLoad);
	assign regs.loadSel = isLoad;

	assign alu.op = aluOpT'(ir.op);
	assign alu.immSel = (ir.grp == grpAluImm4) || (ir.grp == grpAluImm8);
	assign alu.imm = (ir.grp == grpAluImm8) ? wordT'({ir.rd, ir.rs}) : wordT'(ir.rs);
	assign alu.flagEn = isAluGrp;

	// Strobe requests are for the next cycle, the bus registers them
	assign memRead = (nextPhase == phFetch) || ((nextPhase == phExecute) && isLoad);
	assign memWrite = (nextPhase == phExecute) && isStore;

	assign condMet = ir.mode ? !zero : zero;
	assign jumpTaken = isJump && (!ir.op[jmpCondIdx] || condMet);
	assign jumpRel = ir.op[jmpRelIdx];
	assign offset = {ir.rd, ir.rs};

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
	input  logic   CLK,
	input  logic   rstN,
	regPortIf.regs regs,
	output wordT   a,
	output wordT   b,
	input  wordT   aluResult,
	input  wordT   loadData
);

	wordT regBank [regCount];
	wordT wrData;

	assign wrData = regs.loadSel ? loadData : aluResult;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regBank[i] <= '0;
			end
		end else if (regs.wrEn) begin
			regBank[regs.wrSel] <= wrData;
		end
	end

	// Asynchronous reads, a is the destination side
	assign a = regBank[regs.rdSel];
	assign b = regBank[regs.rsSel];

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import cpuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	aluIf.alu    alu,
	input  logic commit
);

	wordT                   opB;
	logic [shiftWidth-1:0]  shAmt;
	logic [2*dataWidth-1:0] rotWide;
	wordT                   bitMask;
	logic                   zeroReg;

	assign opB = alu.immSel ? alu.imm : alu.b;
	assign shAmt = opB[shiftWidth-1:0];

	// Rotate right, low bits wrap to the top
	assign rotWide = {alu.a, alu.a} >> shAmt;
	assign bitMask = wordT'(1) << shAmt;

	always_comb begin
		case (alu.op)
			opMov: alu.result = opB;
			opAdd: alu.result = alu.a + opB;
			opSub: alu.result = alu.a - opB;
			opAnd: alu.result = alu.a & opB;
			opOr: alu.result = alu.a | opB;
			opXor: alu.result = alu.a ^ opB;
			opSl: alu.result = alu.a << shAmt;
			opSr: alu.result = alu.a >> shAmt;
			opSra: alu.result = wordT'($signed(alu.a) >>> shAmt);
			opRot: alu.result = rotWide[dataWidth-1:0];
			opSet: alu.result = alu.a | bitMask;
			opClr: alu.result = alu.a & ~bitMask;
			default: alu.result = alu.a;
		endcase
	end

	// Z only follows ALU instructions
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			zeroReg <= 1'b0;
		end else if (commit && alu.flagEn) begin
			zeroReg <= (alu.result == '0);
		end
	end

	assign alu.zero = zeroReg;

endmodule

// File: hw/busInterface.sv
`timescale 1ns/1ps

module busInterface import cpuPkg::*; (
	input  logic                   CLK,
	input  logic                   rstN,
	input  phaseT                  phase,
	input  logic                   memRead,
	input  logic                   memWrite,
	input  logic                   jumpTaken,
	input  logic                   jumpRel,
	input  logic [offsetWidth-1:0] offset,
	input  wordT                   regAddr,
	input  wordT                   regData,
	input  wordT                   jumpReg,
	input  wordT                   din,
	output wordT                   instr,
	output wordT                   loadData,
	output wordT                   addr,
	output wordT                   dout,
	output logic                   rdN,
	output logic                   wrN
);

	wordT pc;
	wordT pcNext;
	wordT relTarget;
	wordT readReg;

	assign pcNext = pc + wordT'(2);

	// Offset counts words, so scale it to bytes
	assign relTarget = pcNext +
		{{(dataWidth-offsetWidth-1){offset[offsetWidth-1]}}, offset, 1'b0};

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= '0;
		end else if (phase == phCommit) begin
			if (jumpTaken) begin
				pc <= jumpRel ? relTarget : jumpReg;
			end else begin
				pc <= pcNext;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			rdN <= 1'b1;
			wrN <= 1'b1;
		end else begin
			rdN <= !memRead;
			wrN <= !memWrite;
		end
	end

	always_ff @(posedge CLK) begin
		if (memWrite) begin
			dout <= regData;
		end
	end

	// Instruction word and load word share one capture register
	always_ff @(posedge CLK) begin
		if (!rdN) begin
			readReg <= din;
		end
	end

	assign addr = (phase == phExecute) ? regAddr : pc;
	assign instr = readReg;
	assign loadData = readReg;

endmodule

// File: hw/forthCore.sv
`timescale 1ns/1ps

module forthCore import cpuPkg::*; (
	input  logic CLK,
	input  logic rstN,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output wordT addr,
	output wordT dout,
	input  wordT din,
	output logic rdN,
	output logic wrN
);

	aluIf     aluBus ();
	regPortIf regBus ();

	phaseT                  phase;
	logic                   memRead;
	logic                   memWrite;
	logic                   jumpTaken;
	logic                   jumpRel;
	logic [offsetWidth-1:0] offset;
	wordT                   instr;
	wordT                   loadData;
	wordT                   regA;
	wordT                   regB;

	assign aluBus.a = regA;
	assign aluBus.b = regB;

	phaseControl uCtrl (
		.CLK(CLK), .rstN(rstN), .alu(aluBus.ctrl), .regs(regBus.ctrl),
		.instr(instr), .zero(aluBus.zero), .phase(phase),
		.memRead(memRead), .memWrite(memWrite), .jumpTaken(jumpTaken),
		.jumpRel(jumpRel), .offset(offset)
	);

	registerFile uRegs (
		.CLK(CLK), .rstN(rstN), .regs(regBus.regs), .a(regA), .b(regB),
		.aluResult(aluBus.result), .loadData(loadData)
	);

	aluUnit uAlu (.CLK(CLK), .rstN(rstN), .alu(aluBus.alu), .commit(commit));

	// Store data comes from rd, addresses and absolute targets from rs
	busInterface uBus (
		.CLK(CLK), .rstN(rstN), .phase(phase), .memRead(memRead), .memWrite(memWrite),
		.jumpTaken(jumpTaken), .jumpRel(jumpRel), .offset(offset),
		.regAddr(regB), .regData(regA), .jumpReg(regB), .din(din), .instr(instr),
		.loadData(loadData), .addr(addr), .dout(dout), .rdN(rdN), .wrN(wrN)
	);

	assign fetch = (phase == phFetch);
	assign decode = (phase == phDecode);
	assign execute = (phase == phExecute);
	assign commit = (phase == phCommit);

endmodule

// File: dv/forthCoreChecker.sv
`timescale 1ns/1ps

module forthCoreChecker import cpuPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic fetch,
	input logic decode,
	input logic execute,
	input logic commit,
	input wordT addr,
	input wordT dout,
	input wordT din,
	input logic rdN,
	input logic wrN
);

	string testName = "none";
	int    fetchErrs = 0;
	int    storeErrs = 0;
	int    otherErrs = 0;

	wordT  modelRegs [regCount];
	wordT  modelPc;
	logic  modelZ;
	wordT  curInstr;
	wordT  loadWord;
	logic  fetchSeen;
	logic  storeSeen;
	logic  rstSeen = 1'b0;
	logic  [3:0] expPhases;
	logic  warmup;

	// ROT turns right and bit ops take the bit number from b[3:0]
	function automatic wordT aluRef(input logic [3:0] op, input wordT a, input wordT b);
		logic [3:0] n;
		n = b[3:0];
		case (op)
			opMov: return b;
			opAdd: return a + b;
			opSub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opXor: return a ^ b;
			opSl: return a << n;
			opSr: return a >> n;
			opSra: return wordT'($signed(a) >>> n);
			opRot: return (a >> n) | (a << (5'd16 - n));
			opSet: return a | (16'h1 << n);
			opClr: return a & ~(16'h1 << n);
			default: return a;
		endcase
	endfunction

	// Steps the ISA model by one committed instruction
	function automatic void stepIsa(input wordT ins, input wordT ldWord);
		logic [3:0] dst;
		wordT       opB;
		wordT       res;
		wordT       target;
		target = modelPc + 16'd2;
		case (ins[15:13])
			grpAluReg, grpAluImm4, grpAluImm8: begin
				dst = (ins[15:13] == grpAluImm8) ? regRb : ins[7:4];
				opB = (ins[15:13] == grpAluReg) ? modelRegs[ins[3:0]] :
					(ins[15:13] == grpAluImm4) ? {12'h0, ins[3:0]} : {8'h0, ins[7:0]};
				res = aluRef(ins[11:8], modelRegs[dst], opB);
				modelRegs[dst] = res;
				modelZ = (res == 16'h0);
			end
			grpLdSt: begin
				if (!ins[12]) begin
					modelRegs[ins[7:4]] = ldWord;
				end
			end
			grpJump: begin
				if (!ins[11] || (ins[12] ? !modelZ : modelZ)) begin
					target = ins[10] ? modelPc + 16'd2 + {{7{ins[7]}}, ins[7:0], 1'b0} :
						modelRegs[ins[3:0]];
				end
			end
			default: begin
			end
		endcase
		modelPc = target;
	endfunction

	always @(posedge CLK) begin
		rstSeen <= !rstN;
	end

	always @(negedge CLK) begin
		if (!rstN) begin
			if (rstSeen && (!rdN || !wrN)) begin
				otherErrs++;
				$display("error %s: a bus strobe is active during reset", testName);
			end
			for (int i = 0; i < regCount; i++) begin
				modelRegs[i] = '0;
			end
			modelPc = '0;
			modelZ = 1'b0;
			fetchSeen = 1'b0;
			expPhases = 4'b1000;
			warmup = 1'b1;
		end else begin
			// One idle fetch cycle after reset, then one phase per cycle
			if ({fetch, decode, execute, commit} !== expPhases) begin
				otherErrs++;
				$display("error %s: phase outputs expected %b actual %b", testName,
					expPhases, {fetch, decode, execute, commit});
			end
			if (fetch && rdN && !warmup) begin
				otherErrs++;
				$display("error %s: fetch cycle without a read strobe", testName);
			end
			if (!wrN && !execute) begin
				otherErrs++;
				$display("error %s: write strobe outside the execute phase", testName);
			end
			if (!rdN && !wrN) begin
				otherErrs++;
				$display("error %s: read and write strobes low together", testName);
			end
			expPhases = warmup ? 4'b1000 : {commit, fetch, decode, execute};
			warmup = 1'b0;
			if (fetch && !rdN) begin
				if (addr !== modelPc) begin
					fetchErrs++;
					$display("error %s: fetch address expected %h actual %h",
						testName, modelPc, addr);
				end
				curInstr = din;
				fetchSeen = 1'b1;
				storeSeen = 1'b0;
			end
			if (execute && !rdN) begin
				if (curInstr[15:12] != {grpLdSt, 1'b0}) begin
					otherErrs++;
					$display("error %s: read strobe outside a load", testName);
				end else if (addr !== modelRegs[curInstr[3:0]]) begin
					otherErrs++;
					$display("error %s: load address expected %h actual %h",
						testName, modelRegs[curInstr[3:0]], addr);
				end
				loadWord = din;
			end
			if (execute && !wrN) begin
				if (curInstr[15:12] != {grpLdSt, 1'b1}) begin
					otherErrs++;
					$display("error %s: write strobe outside a store", testName);
				end else begin
					storeSeen = 1'b1;
					if (addr !== modelRegs[curInstr[3:0]] ||
							dout !== modelRegs[curInstr[7:4]]) begin
						storeErrs++;
						$display("error %s: store expected %h at %h actual %h at %h", testName,
							modelRegs[curInstr[7:4]], modelRegs[curInstr[3:0]], dout, addr);
					end
				end
			end
			if (commit) begin
				if (!fetchSeen) begin
					otherErrs++;
					$display("error %s: instruction committed without a fetch", testName);
				end
				if (curInstr[15:12] == {grpLdSt, 1'b1} && !storeSeen) begin
					otherErrs++;
					$display("error %s: store instruction never wrote memory", testName);
				end
				stepIsa(curInstr, loadWord);
				fetchSeen = 1'b0;
			end
		end
	end

endmodule

// File: dv/forthCore_assert.sv
`timescale 1ns/1ps

module forthCoreAssert import cpuPkg::*; (
	input logic  CLK,
	input logic  rstN,
	input phaseT phase,
	input logic  memRead,
	input logic  memWrite
);

	int failCount = 0;

	// Fetch may repeat once right after reset, the other phases never do
	phaseRing: assert property (@(posedge CLK) disable iff (!rstN)
		phase != phFetch |=> phase == phaseT'($past(phase) + 2'd1))
		else begin
			failCount++;
			$error("phase did not advance to the next phase");
		end

	fetchExit: assert property (@(posedge CLK) disable iff (!rstN)
		phase == phFetch |=> phase inside {phFetch, phDecode})
		else begin
			failCount++;
			$error("fetch was followed by a phase other than decode");
		end

	strobeExclusive: assert property (@(posedge CLK) disable iff (!rstN)
		!(memRead && memWrite))
		else begin
			failCount++;
			$error("read and write strobes requested together");
		end

	// The write request leads the strobe by one cycle
	writeInExecute: assert property (@(posedge CLK) disable iff (!rstN)
		memWrite |-> phase == phDecode ##1 phase == phExecute)
		else begin
			failCount++;
			$error("write strobe outside the execute phase");
		end

endmodule

bind phaseControl forthCoreAssert uPhaseAssert (
	.CLK(CLK),
	.rstN(rstN),
	.phase(phase),
	.memRead(memRead),
	.memWrite(memWrite)
);

// File: dv/forthCoreTb.sv
`timescale 1ns/1ps

module forthCoreTb import cpuPkg::*; ();

	localparam int memWords = 32768;
	localparam wordT nopWord = {grpSys, 13'h0};
	// Unconditional relative jump back onto itself
	localparam wordT haltWord = {grpJump, 1'b0, 4'b0100, 8'hff};

	logic CLK;
	logic rstN;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	wordT addr;
	wordT dout;
	wordT din;
	logic rdN;
	logic wrN;

	wordT        mem [memWords];
	int          wp;
	int          tbErrs = 0;
	logic [31:0] lfsr = 32'h9d3f_edc3;
	longint      cycles = 0;
	longint      cycleBudget = 64;

	forthCore uut (
		.CLK(CLK), .rstN(rstN), .fetch(fetch), .decode(decode), .execute(execute),
		.commit(commit), .addr(addr), .dout(dout), .din(din), .rdN(rdN), .wrN(wrN)
	);

	forthCoreChecker chk (
		.CLK(uut.CLK), .rstN(uut.rstN), .fetch(uut.fetch), .decode(uut.decode),
		.execute(uut.execute), .commit(uut.commit), .addr(uut.addr), .dout(uut.dout),
		.din(uut.din), .rdN(uut.rdN), .wrN(uut.wrN)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Zero-wait memory answers within the strobe's own cycle
	always @(posedge CLK) begin
		#2;
		if (!wrN) begin
			mem[addr[15:1]] = dout;
		end
		if (!rdN) begin
			din = mem[addr[15:1]];
		end
	end

	// Budget is raised by each program as it starts
	initial begin
		while (cycles <= cycleBudget) begin
			@(posedge CLK);
			cycles++;
		end
		$display("watchdog expired after %0d cycles, a program never reached its halt",
			cycles);
		$display("** FAIL **");
		$finish;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [7:0] randBits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic wordT fillWord(input int idx);
		return wordT'(idx * 40503) ^ 16'h3c5a;
	endfunction

	function automatic wordT enc(input logic [2:0] grp, input logic mode,
			input logic [3:0] op, input logic [7:0] low);
		return {grp, mode, op, low};
	endfunction

	task automatic emit(input wordT w);
		mem[wp] = w;
		wp++;
	endtask

	task automatic startProgram(input string name);
		@(posedge CLK);
		#2;
		rstN = 1'b0;
		chk.testName = name;
		for (int i = 0; i < memWords; i++) begin
			mem[i] = fillWord(i);
		end
		wp = 0;
	endtask

	task automatic runProgram();
		int haltAddr;
		int halts;
		haltAddr = wp * 2;
		emit(haltWord);
		cycleBudget = cycles + wp * 4 + 16 + 48;
		repeat (16) @(posedge CLK);
		#2;
		rstN = 1'b1;
		halts = 0;
		while (halts < 2) begin
			@(negedge CLK);
			if (fetch && !rdN && addr == haltAddr) begin
				halts++;
			end
		end
	endtask

	initial begin
		logic [1:0] kind;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		rstN = 1'b0;
		din = '0;

		startProgram("alu");
		// Store pointer r14 = 0x400 with RB = 0xc7 and r3 = 5
		emit(enc(grpAluImm8, 1'b0, opMov, 8'h04));
		emit(enc(grpAluReg, 1'b0, opMov, 8'heb));
		emit(enc(grpAluImm4, 1'b0, opSl, 8'he8));
		emit(enc(grpAluImm8, 1'b0, opMov, 8'hc7));
		emit(enc(grpAluImm4, 1'b0, opMov, 8'h35));
		for (int i = 0; i < 12; i++) begin
			emit(enc(grpAluReg, 1'b0, opMov, 8'h2b));
			emit(enc(grpAluReg, 1'b0, i[3:0], 8'h23));
			emit(enc(grpLdSt, 1'b1, 4'h0, 8'h2e));
			emit(enc(grpAluImm4, 1'b0, i[3:0], {4'h2, 4'(i + 4)}));
			emit(enc(grpLdSt, 1'b1, 4'h0, 8'h2e));
			emit(enc(grpAluImm8, 1'b0, i[3:0], 8'h5a ^ 8'(i)));
			emit(enc(grpLdSt, 1'b1, 4'h0, 8'hbe));
		end
		// Load r5 from 0xf000 and store it back at r14
		emit(enc(grpAluImm8, 1'b0, opMov, 8'hf0));
		emit(enc(grpAluReg, 1'b0, opMov, 8'hdb));
		emit(enc(grpAluImm4, 1'b0, opSl, 8'hd8));
		emit(enc(grpLdSt, 1'b0, 4'h0, 8'h5d));
		emit(enc(grpLdSt, 1'b1, 4'h0, 8'h5e));
		runProgram();
		if (mem[16'h0200] !== fillWord(16'h7800)) begin
			tbErrs++;
			$display("error alu: loaded word at store expected %h actual %h",
				fillWord(16'h7800), mem[16'h0200]);
		end

		startProgram("jump");
		for (int z = 0; z < 2; z++) begin
			// k selects jump on Z set, jump on Z clear, then always
			for (int k = 0; k < 3; k++) begin
				emit(enc(grpAluImm4, 1'b0, opMov, {4'h1, 3'b000, z[0]}));
				emit(enc(grpJump, k == 1, {k < 2, 3'b100}, 8'h01));
				emit(nopWord);
				emit(enc(grpAluImm8, 1'b0, opMov, 8'(wp * 2 + 10)));
				emit(enc(grpAluReg, 1'b0, opMov, 8'h7b));
				emit(enc(grpAluImm4, 1'b0, opMov, {4'h1, 3'b000, z[0]}));
				emit(enc(grpJump, k == 1, {k < 2, 3'b000}, 8'h07));
				emit(nopWord);
			end
		end
		runProgram();

		startProgram("random");
		emit(enc(grpAluImm8, 1'b0, opMov, 8'h40));
		emit(enc(grpAluReg, 1'b0, opMov, 8'heb));
		emit(enc(grpAluImm4, 1'b0, opSl, 8'he8));
		for (int i = 0; i < 200; i++) begin
			kind = randBits(2);
			op = randBits(4) % 12;
			rd = randBits(4) % 12;
			rs = randBits(4);
			case (kind)
				2'd0: emit(enc(grpAluReg, 1'b0, op, {rd, rs % 4'd12}));
				2'd1: emit(enc(grpAluImm4, 1'b0, op, {rd, rs}));
				2'd2: emit(enc(grpAluImm8, 1'b0, op, randBits(8)));
				default: emit(enc(grpLdSt, 1'b1, 4'h0, {rd, 4'he}));
			endcase
		end
		runProgram();

		$display("errors: fetch %0d, store %0d, other %0d, testbench %0d, assertion %0d",
			chk.fetchErrs, chk.storeErrs, chk.otherErrs, tbErrs,
			uut.uCtrl.uPhaseAssert.failCount);
		if (chk.fetchErrs + chk.storeErrs + chk.otherErrs + tbErrs +
				uut.uCtrl.uPhaseAssert.failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: forthCore.f
hw/cpuPkg.sv
hw/coreIfs.sv
hw/phaseControl.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/busInterface.sv
hw/forthCore.sv
dv/forthCoreChecker.sv
dv/forthCore_assert.sv
dv/forthCoreTb.sv

// File: Bender.yml
package:
  name: forthCore

sources:
  - hw/cpuPkg.sv
  - hw/coreIfs.sv
  - hw/phaseControl.sv
  - hw/registerFile.sv
  - hw/aluUnit.sv
  - hw/busInterface.sv
  - hw/forthCore.sv
  - target: test
    files:
      - dv/forthCoreChecker.sv
      - dv/forthCore_assert.sv
      - dv/forthCoreTb.sv
